// ==== common/dma_cmd_pkg.sv ====
`default_nettype none

package dma_cmd_pkg;

	localparam int QUEUE_DEPTH = 8;

	// Status word of REG_CMD reads
	localparam logic [31:0] STATUS_BUSY = 32'hffff_ffff;
	localparam logic [31:0] STATUS_IDLE = 32'h0000_0000;

	typedef enum logic [1:0] {
		OP_NOP = 2'd0,
		OP_FILL = 2'd1,
		OP_COPY = 2'd2
	} dma_op_t;

	typedef enum logic [1:0] {
		REG_SRC = 2'd0,		// Source address or fill value
		REG_DST = 2'd1,
		REG_COUNT = 2'd2,	// Words to move
		REG_CMD = 2'd3		// Write pushes, read gives status
	} dma_reg_t;

	typedef struct packed {
		dma_op_t op;
		logic [31:0] value_or_from;
		logic [31:0] to;
		logic [31:0] count;
	} dma_cmd_t;

endpackage

`default_nettype wire

// ==== common/dma_bus_pkg.sv ====
`default_nettype none

package dma_bus_pkg;

	localparam int BUS_DATA_W = 32;

	typedef logic [BUS_DATA_W-1:0] bus_word_t;

	localparam bus_word_t BUS_WORD_STEP = 32'd4;	// Byte address step per word

	localparam logic BUS_READ = 1'b0;
	localparam logic BUS_WRITE = 1'b1;

	typedef struct packed {
		logic rw;
		bus_word_t address;
		bus_word_t wdata;
	} bus_req_t;

endpackage

`default_nettype wire

// ==== hdl/dma_reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_reg_decode (
	input wire i_clock,
	input wire i_reset,

	input wire i_request,
	input wire i_rw,
	input dma_cmd_pkg::dma_reg_t i_address,
	input wire [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic o_ready,

	input wire i_queue_full,
	input wire i_busy,		// Engine busy or queue holds commands

	output logic o_push,
	output dma_cmd_pkg::dma_cmd_t o_cmd
);

	logic cmd_write;
	logic accept;

	assign cmd_write = i_rw && (i_address == dma_cmd_pkg::REG_CMD);

	// New request, held off on a full queue
	assign accept = i_request && !o_ready && !(cmd_write && i_queue_full);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_push <= 1'b0;
		end else begin
			o_push <= accept && cmd_write;
			if (!i_request)
				o_ready <= 1'b0;
			else if (accept)
				o_ready <= 1'b1;
		end
	end

	// Staging command and read data
	always_ff @(posedge i_clock) begin
		if (accept) begin
			if (i_rw) begin
				case (i_address)
					dma_cmd_pkg::REG_SRC: o_cmd.value_or_from <= i_wdata;
					dma_cmd_pkg::REG_DST: o_cmd.to <= i_wdata;
					dma_cmd_pkg::REG_COUNT: o_cmd.count <= i_wdata;
					dma_cmd_pkg::REG_CMD: o_cmd.op <= dma_cmd_pkg::dma_op_t'(i_wdata[1:0]);
					default: ;
				endcase
			end else if (i_address == dma_cmd_pkg::REG_CMD) begin
				o_rdata <= i_busy ? dma_cmd_pkg::STATUS_BUSY : dma_cmd_pkg::STATUS_IDLE;
			end else begin
				o_rdata <= 32'd0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/dma_cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_cmd_fifo #(
	parameter int DEPTH = dma_cmd_pkg::QUEUE_DEPTH
) (
	input wire i_clock,
	input wire i_reset,

	input wire i_push,
	input dma_cmd_pkg::dma_cmd_t i_data,
	input wire i_pop,
	output dma_cmd_pkg::dma_cmd_t o_data,

	output logic o_empty,
	output logic o_full
);

	dma_cmd_pkg::dma_cmd_t mem [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;

	logic do_push;
	logic do_pop;

	assign o_empty = (count == '0);
	assign o_full = (count == ($clog2(DEPTH+1))'(DEPTH));

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
		if (do_pop)
			o_data <= mem[rd_ptr];	// Valid the cycle after pop
	end

endmodule

`default_nettype wire

// ==== dma_engine/dma_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_engine (
	input wire i_clock,
	input wire i_reset,

	// Command queue
	input wire i_empty,
	input dma_cmd_pkg::dma_cmd_t i_cmd,
	output logic o_pop,

	input wire i_stall,
	output logic o_busy,

	// Bus master
	output logic o_bus_request,
	output dma_bus_pkg::bus_req_t o_bus,
	input wire i_bus_ready,
	input wire [31:0] i_bus_rdata
);

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		FILL_REQ,
		FILL_WAIT,
		COPY_RD_REQ,
		COPY_RD_WAIT,
		COPY_WR_REQ,
		COPY_WR_WAIT
	} state_t;

	state_t state;

	dma_cmd_pkg::dma_cmd_t cur;		// Addresses advance, count runs down
	logic [31:0] hold;				// Copy data between read and write
	logic last_word;

	assign o_pop = (state == IDLE) && !i_empty;
	assign o_busy = (state != IDLE);
	assign last_word = (cur.count == 32'd1);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			o_bus_request <= 1'b0;
		end else begin
			case (state)
				IDLE:
					if (!i_empty)
						state <= LOAD;

				LOAD: begin
					// Zero count or unknown opcode is dropped
					if (i_cmd.count == 32'd0)
						state <= IDLE;
					else if (i_cmd.op == dma_cmd_pkg::OP_FILL)
						state <= FILL_REQ;
					else if (i_cmd.op == dma_cmd_pkg::OP_COPY)
						state <= COPY_RD_REQ;
					else
						state <= IDLE;
				end

				FILL_REQ, COPY_RD_REQ, COPY_WR_REQ:
					if (!i_stall) begin
						o_bus_request <= 1'b1;
						state <= state_t'(state + 3'd1);	// Matching WAIT state
					end

				FILL_WAIT:
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= last_word ? IDLE : FILL_REQ;
					end

				COPY_RD_WAIT:
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= COPY_WR_REQ;
					end

				COPY_WR_WAIT:
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= last_word ? IDLE : COPY_RD_REQ;
					end

				default:
					state <= IDLE;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge i_clock) begin
		case (state)
			LOAD:
				cur <= i_cmd;

			FILL_REQ:
				if (!i_stall) begin
					o_bus.rw <= dma_bus_pkg::BUS_WRITE;
					o_bus.address <= cur.to;
					o_bus.wdata <= cur.value_or_from;
				end

			COPY_RD_REQ:
				if (!i_stall) begin
					o_bus.rw <= dma_bus_pkg::BUS_READ;
					o_bus.address <= cur.value_or_from;
				end

			COPY_WR_REQ:
				if (!i_stall) begin
					o_bus.rw <= dma_bus_pkg::BUS_WRITE;
					o_bus.address <= cur.to;
					o_bus.wdata <= hold;
				end

			COPY_RD_WAIT:
				if (i_bus_ready) begin
					hold <= i_bus_rdata;
					cur.value_or_from <= cur.value_or_from + dma_bus_pkg::BUS_WORD_STEP;
				end

			FILL_WAIT, COPY_WR_WAIT:
				if (i_bus_ready) begin
					cur.to <= cur.to + dma_bus_pkg::BUS_WORD_STEP;
					cur.count <= cur.count - 32'd1;
				end

			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/dma_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_top (
	input wire i_clock,
	input wire i_reset,

	// CPU port
	input wire i_request,
	input wire i_rw,
	input dma_cmd_pkg::dma_reg_t i_address,
	input wire [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic o_ready,

	input wire i_stall,

	// Bus port
	output logic o_bus_request,
	output dma_bus_pkg::bus_req_t o_bus,
	input wire i_bus_ready,
	input wire [31:0] i_bus_rdata
);

	dma_cmd_pkg::dma_cmd_t push_cmd;
	dma_cmd_pkg::dma_cmd_t pop_cmd;
	logic push;
	logic pop;
	logic queue_empty;
	logic queue_full;
	logic engine_busy;
	logic status_busy;

	assign status_busy = engine_busy || !queue_empty;	// Status seen by the CPU

	dma_reg_decode u_decode (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.i_queue_full(queue_full),
		.i_busy(status_busy),
		.o_push(push),
		.o_cmd(push_cmd)
	);

	dma_cmd_fifo #(
		.DEPTH(dma_cmd_pkg::QUEUE_DEPTH)
	) u_queue (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_push(push),
		.i_data(push_cmd),
		.i_pop(pop),
		.o_data(pop_cmd),
		.o_empty(queue_empty),
		.o_full(queue_full)
	);

	dma_engine u_engine (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_empty(queue_empty),
		.i_cmd(pop_cmd),
		.o_pop(pop),
		.i_stall(i_stall),
		.o_busy(engine_busy),
		.o_bus_request(o_bus_request),
		.o_bus(o_bus),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

`default_nettype wire

// ==== bench/dma_bus_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_bus_memory (
	input wire i_clock,
	input wire i_reset,
	input wire i_bus_request,
	input dma_bus_pkg::bus_req_t i_bus,
	output logic o_bus_ready,
	output logic [31:0] o_bus_rdata
);

	localparam logic [31:0] LFSR_SEED = 32'h65bc;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic [31:0] lfsr;
	logic [31:0] step_one;
	logic [31:0] step_two;
	logic [1:0] wait_left;
	logic waiting;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	assign step_one = lfsr_next(lfsr);
	assign step_two = lfsr_next(step_one);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			lfsr <= LFSR_SEED;
			o_bus_ready <= 1'b0;
			waiting <= 1'b0;
			wait_left <= 2'd0;
			o_bus_rdata <= 32'd0;
		end else begin
			o_bus_ready <= 1'b0;
			if (i_bus_request && !o_bus_ready && !waiting) begin
				wait_left <= {step_one[0], step_two[0]};	// Two bits of delay
				lfsr <= step_two;
				waiting <= 1'b1;
			end else if (waiting) begin
				if (wait_left == 2'd0) begin
					o_bus_ready <= 1'b1;
					o_bus_rdata <= i_bus.address ^ 32'hc0de_0000;	// Preload pattern
					waiting <= 1'b0;
				end else begin
					wait_left <= wait_left - 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/dma_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_checker (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire o_ready,
	input wire i_stall,
	input wire o_bus_request,
	input dma_bus_pkg::bus_req_t o_bus,
	input wire i_bus_ready
);

	bus_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus))
		else $error("Bus request dropped or changed before ready");

	// Ready may lag one cycle behind a dropped request
	ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_request && !$past(i_request) |-> !o_ready)
		else $error("CPU ready high without a request");

	no_start_in_stall: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_bus_request) |-> !$past(i_stall))
		else $error("Bus request started during stall");

endmodule

bind dma_top dma_checker u_checker (.*);

`default_nettype wire

// ==== bench/dma_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_tb;

	localparam int CLOCK_PERIOD = 8;

	logic i_clock = 1'b0;
	logic i_reset = 1'b1;
	logic i_request = 1'b0;
	logic i_rw = 1'b0;
	dma_cmd_pkg::dma_reg_t i_address = dma_cmd_pkg::REG_SRC;
	logic [31:0] i_wdata = 32'd0;
	logic [31:0] o_rdata;
	logic o_ready;
	logic i_stall = 1'b0;
	logic o_bus_request;
	dma_bus_pkg::bus_req_t o_bus;
	logic i_bus_ready;
	logic [31:0] i_bus_rdata;

	logic [31:0] trace [0:255];
	dma_bus_pkg::bus_req_t seen [$];
	int cycle = 0;
	int stall_from = 0;
	int stall_to = 0;
	int limit_cycles = 0;
	int errors = 0;

	always #(CLOCK_PERIOD / 2) i_clock = ~i_clock;

	dma_top UUT (.*);

	dma_bus_memory u_memory (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_request(o_bus_request),
		.i_bus(o_bus),
		.o_bus_ready(i_bus_ready),
		.o_bus_rdata(i_bus_rdata)
	);

	always @(posedge i_clock) begin
		cycle <= cycle + 1;
		i_stall <= (cycle >= stall_from) && (cycle < stall_to);	// Stall window
		if (!i_reset && o_bus_request && i_bus_ready && o_bus.rw == dma_bus_pkg::BUS_WRITE)
			seen.push_back(o_bus);
	end

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge i_clock);
		$display("Timeout: run did not finish within %0d cycles", limit_cycles);
		$display("** FAIL **");
		$finish;
	end

	task automatic cpu_access(input logic rw, input dma_cmd_pkg::dma_reg_t addr,
			input logic [31:0] data, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge i_clock);
		i_request <= 1'b1;
		i_rw <= rw;
		i_address <= addr;
		i_wdata <= data;
		do begin
			@(posedge i_clock);
			#1;
			waited++;
		end while (!o_ready && waited < 4000);
		if (!o_ready) begin
			$display("CPU access to register %0d got no ready", addr);
			errors++;
		end
		rdata = o_rdata;
		@(posedge i_clock);
		i_request <= 1'b0;
	endtask

	task automatic check_bus_write(input dma_bus_pkg::bus_req_t got,
			input dma_bus_pkg::bus_req_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: bus write %h <= %h, expected %h <= %h",
				$time, got.address, got.wdata, exp.address, exp.wdata);
			errors++;
		end
	endtask

	task automatic check_status(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: status %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic run_test(input int num, inout int pos);
		int ncmd;
		int nwrites;
		int polls;
		int errors_before;
		logic [31:0] rd;
		dma_bus_pkg::bus_req_t exp;
		errors_before = errors;
		ncmd = int'(trace[pos]);
		nwrites = int'(trace[pos+3]);
		stall_from = cycle + int'(trace[pos+1]);
		stall_to = stall_from + int'(trace[pos+2]);
		pos += 4;
		seen.delete();
		for (int c = 0; c < ncmd; c++) begin
			cpu_access(1'b1, dma_cmd_pkg::REG_SRC, trace[pos+1], rd);
			cpu_access(1'b1, dma_cmd_pkg::REG_DST, trace[pos+2], rd);
			cpu_access(1'b1, dma_cmd_pkg::REG_COUNT, trace[pos+3], rd);
			cpu_access(1'b1, dma_cmd_pkg::REG_CMD, trace[pos], rd);
			pos += 4;
		end
		cpu_access(1'b0, dma_cmd_pkg::REG_CMD, 32'd0, rd);
		check_status(rd, 32'hffff_ffff);
		polls = 0;
		do begin
			cpu_access(1'b0, dma_cmd_pkg::REG_CMD, 32'd0, rd);
			polls++;
		end while (rd !== 32'd0 && polls < 2000);
		if (rd !== 32'd0)
			$display("Status never returned to idle in test %0d", num);
		check_status(rd, 32'd0);
		if (seen.size() != nwrites) begin
			$display("Test %0d saw %0d bus writes instead of %0d", num, seen.size(), nwrites);
			errors++;
		end
		for (int w = 0; w < nwrites; w++) begin
			exp.rw = dma_bus_pkg::BUS_WRITE;
			exp.address = trace[pos];
			exp.wdata = trace[pos+1];
			if (w < seen.size())
				check_bus_write(seen[w], exp);
			pos += 2;
		end
		if (errors == errors_before)
			$display("Test %0d: passed", num);
		else
			$display("Test %0d: failed", num);
	endtask

	initial begin
		int ntests;
		int pos;
		int passed;
		int errors_before;
		$readmemh("bench/dma_trace.txt", trace);
		ntests = int'(trace[0]);
		pos = 1;
		limit_cycles = 5000;
		for (int t = 0; t < ntests; t++) begin
			limit_cycles += int'(trace[pos+2]) + 200 * int'(trace[pos]) + 60 * int'(trace[pos+3]);
			pos += 4 + 4 * int'(trace[pos]) + 2 * int'(trace[pos+3]);
		end
		repeat (2) @(posedge i_clock);
		i_reset <= 1'b0;
		pos = 1;
		passed = 0;
		for (int t = 0; t < ntests; t++) begin
			errors_before = errors;
			run_test(t + 1, pos);
			if (errors == errors_before)
				passed++;
		end
		$display("Tests: %0d passed, %0d failed, %0d errors", passed, ntests - passed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/dma_trace.txt ====
// Test header: commands stall_start stall_length writes, then commands as op src dst count
// then expected writes as address data pairs
5
1 0 0 4
1 deadbeef 00001000 4
00001000 deadbeef 00001004 deadbeef
00001008 deadbeef 0000100c deadbeef
1 0 0 3
2 00002000 00003000 3
00003000 c0de2000 00003004 c0de2004
00003008 c0de2008
a 0 190 a
1 00000000 00004000 1
1 00000001 00004010 1
1 00000002 00004020 1
1 00000003 00004030 1
1 00000004 00004040 1
1 00000005 00004050 1
1 00000006 00004060 1
1 00000007 00004070 1
1 00000008 00004080 1
1 00000009 00004090 1
00004000 00000000 00004010 00000001 00004020 00000002 00004030 00000003
00004040 00000004 00004050 00000005 00004060 00000006 00004070 00000007
00004080 00000008 00004090 00000009
1 3 14 4
2 00005000 00006000 4
00006000 c0de5000 00006004 c0de5004
00006008 c0de5008 0000600c c0de500c
3 0 0 2
1 11111111 00007000 0
3 22222222 00007100 5
1 33333333 00007200 2
00007200 33333333 00007204 33333333

// ==== project.f ====
common/dma_cmd_pkg.sv
common/dma_bus_pkg.sv
hdl/dma_reg_decode.sv
hdl/dma_cmd_fifo.sv
dma_engine/dma_engine.sv
hdl/dma_top.sv
bench/dma_bus_memory.sv
bench/dma_checker.sv
bench/dma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module dma_tb -o Vdma_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vdma_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
	exit 1
fi
exit 0
